// File: stbuf_top.f
src/stbuf_cfg_pkg.sv
src/stbuf_op_pkg.sv
src/stbuf_amo_alu.sv
src/stbuf_arbiter.sv
src/stbuf_data_ram.sv
src/stbuf_entry.sv
src/stbuf_top.sv
bench/stbuf_asserts.sv
bench/stbuf_tb.sv

// File: bench/stbuf_tb.sv
// ----------------------------------------------------------------------
// Store buffer testbench
// Random stores, AMOs and loads from a fixed seed, checked against a
// word memory model. AMO responses are matched per word address while
// i_resp_ready is toggled at random in the back-pressure phases.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module stbuf_tb
  import stbuf_cfg_pkg::*;
  import stbuf_op_pkg::*;
();

  localparam int AW = 4;
  localparam int NW = 2 ** AW;

  logic              i_clk, i_reset_n;
  logic              i_st_valid, o_st_ready;
  logic [AW-1:0]     i_st_addr;
  logic [WORD_W-1:0] i_st_data;
  logic [3:0]        i_st_strb;
  stbuf_op_t         i_st_op;
  logic              i_ld_valid, o_ld_ready, o_ld_rvalid;
  logic [AW-1:0]     i_ld_addr;
  logic [WORD_W-1:0] o_ld_rdata;
  logic              o_resp_valid, i_resp_ready;
  logic [AW-1:0]     o_resp_addr;
  logic [WORD_W-1:0] o_resp_data;

  integer            seed     = 32'h675e79e0;
  integer            rdy_seed = 32'h675e79e0;  // Separate stream for i_resp_ready
  logic [WORD_W-1:0] model_mem [NW];
  logic [WORD_W-1:0] amo_exp [NW];   // Old word each pending AMO must return
  logic              amo_pend [NW];
  logic              bp_mode;
  int                fail_count;
  logic [AW-2:0]     line;
  logic [AW-1:0]     addr;

  stbuf_top #(.P_ADDR_W(AW), .P_ENTRIES(4)) UUT (
    .i_clk(i_clk),           .i_reset_n(i_reset_n),
    .i_st_valid(i_st_valid), .i_st_addr(i_st_addr),   .i_st_data(i_st_data),
    .i_st_strb(i_st_strb),   .i_st_op(i_st_op),       .o_st_ready(o_st_ready),
    .i_ld_valid(i_ld_valid), .i_ld_addr(i_ld_addr),   .o_ld_ready(o_ld_ready),
    .o_ld_rvalid(o_ld_rvalid), .o_ld_rdata(o_ld_rdata),
    .o_resp_valid(o_resp_valid), .o_resp_addr(o_resp_addr),
    .o_resp_data(o_resp_data),   .i_resp_ready(i_resp_ready)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // ------------------------------------------------------------------
  // Reference model and checking
  // ------------------------------------------------------------------
  task automatic fail_now(input string what);
    $display("%s", what);
    fail_count++;
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] amo_calc(stbuf_op_t op, logic [31:0] old_w,
                                           logic [31:0] opnd);
    case (op)
      OP_SWAP: return opnd;
      OP_ADD:  return old_w + opnd;
      OP_AND:  return old_w & opnd;
      OP_OR:   return old_w | opnd;
      OP_XOR:  return old_w ^ opnd;
      OP_MAX:  return ($signed(old_w) > $signed(opnd)) ? old_w : opnd;
      OP_MIN:  return ($signed(old_w) < $signed(opnd)) ? old_w : opnd;
      default: return old_w;
    endcase
  endfunction

  function automatic logic line_busy(logic [AW-1:0] a);
    return amo_pend[{a[AW-1:1], 1'b0}] | amo_pend[{a[AW-1:1], 1'b1}];
  endfunction

  function automatic int pending_count();
    int n;
    n = 0;
    for (int i = 0; i < NW; i++) begin
      n += amo_pend[i];
    end
    return n;
  endfunction

  // Called at 1 ns after a rising edge, returns at the same point
  task automatic send_op(input logic [AW-1:0] a, input logic [31:0] data,
                         input logic [3:0] strb, input stbuf_op_t op);
    int waited;
    i_st_valid = 1'b1;
    i_st_addr  = a;
    i_st_data  = data;
    i_st_strb  = strb;
    i_st_op    = op;
    waited     = 0;
    @(negedge i_clk);
    while (!o_st_ready) begin
      waited++;
      if (waited > 1000) fail_now("Timeout: a store or AMO request was never accepted");
      @(negedge i_clk);
    end
    if (op == OP_STORE) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) model_mem[a][b*8 +: 8] = data[b*8 +: 8];
      end
    end else begin
      check_value("amo_pend", amo_pend[a], 0);  // Previous AMO on this word must be done
      amo_exp[a]   = model_mem[a];
      amo_pend[a]  = 1'b1;
      model_mem[a] = amo_calc(op, model_mem[a], data);
    end
    @(posedge i_clk);
    #1 i_st_valid = 1'b0;
  endtask

  task automatic load_check(input logic [AW-1:0] a);
    int waited;
    i_ld_valid = 1'b1;
    i_ld_addr  = a;
    waited     = 0;
    @(negedge i_clk);
    while (!o_ld_ready) begin
      waited++;
      if (waited > 2000) fail_now("Timeout: a load request was never accepted");
      @(negedge i_clk);
    end
    check_value("o_ld_ready_on_busy_line", line_busy(a), 0);
    @(posedge i_clk);
    #1 i_ld_valid = 1'b0;
    // Data is due exactly one cycle after the transfer
    @(negedge i_clk);
    check_value("o_ld_rvalid", o_ld_rvalid, 1);
    check_value("o_ld_rdata", o_ld_rdata, model_mem[a]);
    @(posedge i_clk);
    #1;
  endtask

  // Loading every word waits out each buffered line
  task automatic drain_all();
    int waited;
    for (int a = 0; a < NW; a++) begin
      load_check(AW'(a));
    end
    waited = 0;
    while (pending_count() != 0) begin
      waited++;
      if (waited > 1000) fail_now("Timeout: AMO responses still outstanding after drain");
      @(posedge i_clk);
      #1;
    end
  endtask

  task automatic random_op(input logic [AW-1:0] a, input logic with_loads);
    int kind;
    kind = $unsigned($random(seed)) % 10;
    if (with_loads && kind == 0) begin
      load_check(a);
    end else if (kind < 7) begin
      send_op(a, $random(seed), $random(seed), OP_STORE);
    end else begin
      send_op(a, $random(seed), 4'hf, stbuf_op_t'(3'(1 + $unsigned($random(seed)) % 7)));
    end
  endtask

  // Response side, checked on the cycle before the transfer edge
  always @(negedge i_clk) begin
    if (i_reset_n && o_resp_valid && i_resp_ready) begin
      check_value("o_resp_valid_unexpected", amo_pend[o_resp_addr], 1);
      check_value("o_resp_data", o_resp_data, amo_exp[o_resp_addr]);
      amo_pend[o_resp_addr] = 1'b0;
    end
  end

  always @(negedge i_clk) begin
    if (UUT.u_asserts.fail_count != 0) begin
      fail_now("A concurrent assertion on the store buffer failed");
    end
  end

  always @(posedge i_clk) begin
    #1 i_resp_ready = bp_mode ? (($random(rdy_seed) & 3) == 0) : 1'b1;
  end

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------
  initial begin
    i_reset_n    = 1'b0;
    i_st_valid   = 1'b0;
    i_st_addr    = '0;
    i_st_data    = '0;
    i_st_strb    = '0;
    i_st_op      = OP_STORE;
    i_ld_valid   = 1'b0;
    i_ld_addr    = '0;
    i_resp_ready = 1'b1;
    bp_mode      = 1'b0;
    fail_count   = 0;
    for (int i = 0; i < NW; i++) begin
      model_mem[i] = '0;
      amo_exp[i]   = '0;
      amo_pend[i]  = 1'b0;
    end
    repeat (2) @(posedge i_clk);
    #1 i_reset_n = 1'b1;

    repeat (8) load_check($random(seed));  // Fresh memory reads zero

    repeat (200) send_op($random(seed), $random(seed), $random(seed), OP_STORE);
    drain_all();

    for (int op = 1; op < 8; op++) begin  // Every AMO kind once
      addr = $random(seed);
      send_op(addr, $random(seed), 4'hf, stbuf_op_t'(op));
      load_check(addr);
    end

    line = $random(seed);  // Back-to-back traffic on one line
    repeat (60) begin
      addr = $random(seed);
      addr[AW-1:1] = line;
      random_op(addr, 1'b0);
    end
    drain_all();

    bp_mode = 1'b1;
    repeat (150) random_op($random(seed), 1'b1);
    drain_all();

    repeat (2000) random_op($random(seed), 1'b1);
    bp_mode = 1'b0;
    drain_all();

    if (fail_count == 0 && UUT.u_asserts.fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: bench/stbuf_asserts.sv
// ----------------------------------------------------------------------
// Concurrent checks bound into the store buffer top level
// Memory grant shape, load return timing, response stability and the
// quiet outputs during reset.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module stbuf_asserts
  import stbuf_cfg_pkg::*;
#(
  parameter int P_ADDR_W  = ADDR_W,
  parameter int P_ENTRIES = NUM_ENTRIES
) (
  input logic                i_clk,
  input logic                i_reset_n,
  input logic [P_ENTRIES:0]  i_mem_gnt,
  input logic                i_ld_valid,
  input logic                i_ld_ready,
  input logic                i_ld_rvalid,
  input logic                i_st_ready,
  input logic                i_resp_valid,
  input logic                i_resp_ready,
  input logic [P_ADDR_W-1:0] i_resp_addr,
  input logic [WORD_W-1:0]   i_resp_data
);

  int fail_count = 0;  // Number of failed assertions so far

  a_gnt_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(i_mem_gnt))
    else begin
      fail_count++;
      $error("memory grant is not one-hot");
    end

  // Load data comes back exactly one cycle after the load transfer
  a_ld_rvalid: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_ld_valid && i_ld_ready) |=> i_ld_rvalid)
    else begin
      fail_count++;
      $error("load data missing one cycle after the load transfer");
    end

  a_ld_no_extra: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_ld_valid && i_ld_ready) |=> !i_ld_rvalid)
    else begin
      fail_count++;
      $error("load data returned without a load transfer");
    end

  a_resp_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_resp_valid && !i_resp_ready) |=>
      (i_resp_valid && $stable(i_resp_addr) && $stable(i_resp_data)))
    else begin
      fail_count++;
      $error("response dropped or changed before it was accepted");
    end

  a_reset_quiet: assert property (@(posedge i_clk)
    !i_reset_n |-> (!i_st_ready && !i_ld_rvalid && !i_resp_valid && (i_mem_gnt == '0)))
    else begin
      fail_count++;
      $error("valid output raised during reset");
    end

endmodule

bind stbuf_top stbuf_asserts #(
  .P_ADDR_W(P_ADDR_W),
  .P_ENTRIES(P_ENTRIES)
) u_asserts (
  .i_clk(i_clk),               .i_reset_n(i_reset_n),
  .i_mem_gnt(w_mem_gnt),       .i_ld_valid(i_ld_valid),
  .i_ld_ready(o_ld_ready),     .i_ld_rvalid(o_ld_rvalid),
  .i_st_ready(o_st_ready),     .i_resp_valid(o_resp_valid),
  .i_resp_ready(i_resp_ready), .i_resp_addr(o_resp_addr),
  .i_resp_data(o_resp_data)
);

// File: src/stbuf_top.sv
// ----------------------------------------------------------------------
// Store buffer top level
// Steers each store or AMO into a merging or a free entry, holds loads
// off lines that are still buffered, and shares one memory and one
// response path between the entries through round-robin arbiters.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module stbuf_top
  import stbuf_cfg_pkg::*;
  import stbuf_op_pkg::*;
#(
  parameter int P_ADDR_W  = ADDR_W,
  parameter int P_ENTRIES = NUM_ENTRIES
) (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  // Store and AMO requests
  input  logic                  i_st_valid,
  input  logic [P_ADDR_W-1:0]   i_st_addr,
  input  logic [WORD_W-1:0]     i_st_data,
  input  logic [WORD_BYTES-1:0] i_st_strb,
  input  stbuf_op_t             i_st_op,
  output logic                  o_st_ready,
  // Loads
  input  logic                  i_ld_valid,
  input  logic [P_ADDR_W-1:0]   i_ld_addr,
  output logic                  o_ld_ready,
  output logic                  o_ld_rvalid,
  output logic [WORD_W-1:0]     o_ld_rdata,
  // AMO responses
  output logic                  o_resp_valid,
  output logic [P_ADDR_W-1:0]   o_resp_addr,
  output logic [WORD_W-1:0]     o_resp_data,
  input  logic                  i_resp_ready
);

  localparam int LA_W = P_ADDR_W - WSEL_W;

  logic [P_ENTRIES-1:0] w_valid, w_mergeable, w_is_amo, w_st_hit, w_merge_hit;
  logic [P_ENTRIES-1:0] w_ld_hit, w_alloc_oh, w_load, w_merge, w_resp_req, w_resp_gnt;
  logic [LA_W-1:0]      w_line [P_ENTRIES];
  logic [P_ENTRIES:0]   w_mem_req, w_mem_gnt;   // Top index is the load port
  mem_req_t             w_mem_payload [P_ENTRIES+1];
  mem_req_t             w_mem_out;
  logic                 w_mem_valid;
  logic [LINE_W-1:0]    w_ram_rdata;
  amo_resp_t            w_resp_payload [P_ENTRIES];
  amo_resp_t            w_resp_out;
  logic [WORD_W-1:0]    w_amo_old [P_ENTRIES];
  logic [WORD_W-1:0]    w_amo_opnd [P_ENTRIES];
  stbuf_op_t            w_amo_op [P_ENTRIES];
  logic [WORD_W-1:0]    w_alu_old, w_alu_opnd, w_alu_result;
  stbuf_op_t            w_alu_op;
  logic                 w_can_merge, w_can_alloc, w_st_fire;
  logic                 r_ld_rvalid;
  logic [WSEL_W-1:0]    r_ld_sel;

  // ------------------------------------------------------------------
  // Store steering
  // ------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < P_ENTRIES; i++) begin
      w_st_hit[i] = w_valid[i] && (w_line[i] == i_st_addr[P_ADDR_W-1:WSEL_W]);
      w_ld_hit[i] = w_valid[i] && (w_line[i] == i_ld_addr[P_ADDR_W-1:WSEL_W]);
    end
  end

  assign w_merge_hit = w_st_hit & w_mergeable & ~w_is_amo;
  assign w_alloc_oh  = ~w_valid & (w_valid + 1'b1);  // Lowest idle entry
  assign w_can_merge = (i_st_op == OP_STORE) && (|w_merge_hit);
  assign w_can_alloc = !(|w_st_hit) && !(&w_valid);
  assign o_st_ready  = i_st_valid && (w_can_merge || w_can_alloc);
  assign w_st_fire   = i_st_valid && o_st_ready;
  assign w_merge     = (w_st_fire && w_can_merge) ? w_merge_hit : '0;
  assign w_load      = (w_st_fire && !w_can_merge) ? w_alloc_oh : '0;

  // ------------------------------------------------------------------
  // Entries and the shared AMO unit
  // ------------------------------------------------------------------
  for (genvar g = 0; g < P_ENTRIES; g++) begin : g_entry
    stbuf_entry #(.P_ADDR_W(P_ADDR_W)) u_entry (
      .i_clk(i_clk),                 .i_reset_n(i_reset_n),
      .i_load(w_load[g]),            .i_merge(w_merge[g]),
      .i_addr(i_st_addr),            .i_data(i_st_data),
      .i_strb(i_st_strb),            .i_op(i_st_op),
      .i_mem_gnt(w_mem_gnt[g]),      .i_mem_rdata(w_ram_rdata),
      .i_amo_result(w_alu_result),   .i_resp_ready(w_resp_gnt[g] && i_resp_ready),
      .o_valid(w_valid[g]),          .o_line_addr(w_line[g]),
      .o_mergeable(w_mergeable[g]),  .o_is_amo(w_is_amo[g]),
      .o_mem_req(w_mem_payload[g]),  .o_mem_req_valid(w_mem_req[g]),
      .o_amo_old(w_amo_old[g]),      .o_amo_operand(w_amo_opnd[g]),
      .o_amo_op(w_amo_op[g]),        .o_resp(w_resp_payload[g]),
      .o_resp_valid(w_resp_req[g])
    );
  end

  always_comb begin
    w_alu_old  = '0;
    w_alu_opnd = '0;
    w_alu_op   = OP_STORE;
    for (int i = 0; i < P_ENTRIES; i++) begin
      w_alu_old  = w_alu_old | w_amo_old[i];
      w_alu_opnd = w_alu_opnd | w_amo_opnd[i];
      w_alu_op   = stbuf_op_t'(w_alu_op | w_amo_op[i]);
    end
  end

  stbuf_amo_alu u_amo_alu (
    .i_op(w_alu_op), .i_old(w_alu_old), .i_operand(w_alu_opnd), .o_result(w_alu_result)
  );

  // ------------------------------------------------------------------
  // Memory path, loads join as the last requester
  // ------------------------------------------------------------------
  assign w_mem_req[P_ENTRIES]     = i_ld_valid && !(|w_ld_hit);
  assign w_mem_payload[P_ENTRIES] = '{wr: 1'b0,
                                      line_addr: LINE_ADDR_W'(i_ld_addr[P_ADDR_W-1:WSEL_W]),
                                      data: '0};

  stbuf_arbiter #(.P_NUM(P_ENTRIES + 1), .T_PAYLOAD(mem_req_t)) u_mem_arb (
    .i_clk(i_clk),     .i_reset_n(i_reset_n),    .i_req(w_mem_req),
    .i_payload(w_mem_payload), .i_ready(1'b1),   .o_gnt(w_mem_gnt),
    .o_valid(w_mem_valid),     .o_payload(w_mem_out)
  );

  stbuf_data_ram #(.P_ADDR_W(P_ADDR_W)) u_ram (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_valid(w_mem_valid),
    .i_req(w_mem_out), .o_rdata(w_ram_rdata)
  );

  assign o_ld_ready = w_mem_gnt[P_ENTRIES];  // Only raised for an unblocked load

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ld_rvalid <= 1'b0;
    end else begin
      r_ld_rvalid <= i_ld_valid && o_ld_ready;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ld_valid && o_ld_ready) begin
      r_ld_sel <= i_ld_addr[WSEL_W-1:0];
    end
  end

  assign o_ld_rvalid = r_ld_rvalid;
  assign o_ld_rdata  = w_ram_rdata[r_ld_sel*WORD_W +: WORD_W];

  // ------------------------------------------------------------------
  // AMO responses
  // ------------------------------------------------------------------
  stbuf_arbiter #(.P_NUM(P_ENTRIES), .T_PAYLOAD(amo_resp_t)) u_resp_arb (
    .i_clk(i_clk),      .i_reset_n(i_reset_n),      .i_req(w_resp_req),
    .i_payload(w_resp_payload), .i_ready(i_resp_ready), .o_gnt(w_resp_gnt),
    .o_valid(o_resp_valid),     .o_payload(w_resp_out)
  );

  assign o_resp_addr = w_resp_out.addr[P_ADDR_W-1:0];
  assign o_resp_data = w_resp_out.data;

endmodule

// File: src/stbuf_entry.sv
// ----------------------------------------------------------------------
// Store buffer entry
// Holds one pending line with byte strobes. Reads the line through the
// memory arbiter, overlays its bytes, runs an AMO if needed, writes the
// line back and, for an AMO, offers the old word as a response.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module stbuf_entry
  import stbuf_cfg_pkg::*;
  import stbuf_op_pkg::*;
#(
  parameter int P_ADDR_W = ADDR_W
) (
  input  logic                        i_clk,
  input  logic                        i_reset_n,

  input  logic                        i_load,        // Allocate with this request
  input  logic                        i_merge,       // Merge a store into the line
  input  logic [P_ADDR_W-1:0]         i_addr,
  input  logic [WORD_W-1:0]           i_data,
  input  logic [WORD_BYTES-1:0]       i_strb,
  input  stbuf_op_t                   i_op,

  input  logic                        i_mem_gnt,
  input  logic [LINE_W-1:0]           i_mem_rdata,
  input  logic [WORD_W-1:0]           i_amo_result,
  input  logic                        i_resp_ready,  // Response transferred

  output logic                        o_valid,
  output logic [P_ADDR_W-WSEL_W-1:0]  o_line_addr,
  output logic                        o_mergeable,
  output logic                        o_is_amo,
  output mem_req_t                    o_mem_req,
  output logic                        o_mem_req_valid,
  output logic [WORD_W-1:0]           o_amo_old,
  output logic [WORD_W-1:0]           o_amo_operand,
  output stbuf_op_t                   o_amo_op,
  output amo_resp_t                   o_resp,
  output logic                        o_resp_valid
);

  stbuf_state_t          r_state;
  stbuf_state_t          w_state_next;

  logic [P_ADDR_W-1:0]   r_addr;
  stbuf_op_t             r_op;
  logic [LINE_W-1:0]     r_data;
  logic [LINE_BYTES-1:0] r_strb;
  logic [WORD_W-1:0]     r_amo_old;

  logic [WSEL_W-1:0]     w_in_sel;
  logic [WSEL_W-1:0]     w_sel;
  logic [WORD_BYTES-1:0] w_in_mask;
  logic [LINE_W-1:0]     w_in_data;
  logic [LINE_BYTES-1:0] w_in_strb;
  logic [LINE_W-1:0]     w_data;   // Pending bytes after merge
  logic [LINE_BYTES-1:0] w_strb;
  logic [LINE_W-1:0]     w_fill;   // Pending bytes over the read line
  logic                  w_amo;

  assign w_amo     = (r_op != OP_STORE);
  assign w_in_sel  = i_addr[WSEL_W-1:0];
  assign w_sel     = r_addr[WSEL_W-1:0];
  assign w_in_mask = (i_op == OP_STORE) ? i_strb : '1;  // AMO owns its whole word
  assign w_in_data = {WORDS_PER_LINE{i_data}};
  assign w_in_strb = LINE_BYTES'(w_in_mask) << (w_in_sel * WORD_BYTES);

  // ------------------------------------------------------------------
  // Byte merge, newer bytes win
  // ------------------------------------------------------------------
  always_comb begin
    w_data = r_data;
    w_strb = r_strb;
    if (i_merge) begin
      for (int b = 0; b < LINE_BYTES; b++) begin
        if (w_in_strb[b]) begin
          w_data[b*8 +: 8] = w_in_data[b*8 +: 8];
          w_strb[b]        = 1'b1;
        end
      end
    end
    for (int b = 0; b < LINE_BYTES; b++) begin
      w_fill[b*8 +: 8] = w_strb[b] ? w_data[b*8 +: 8] : i_mem_rdata[b*8 +: 8];
    end
  end

  // ------------------------------------------------------------------
  // State machine
  // ------------------------------------------------------------------
  always_comb begin
    w_state_next = r_state;
    case (r_state)
      ST_IDLE:    if (i_load)    w_state_next = ST_RD_REQ;
      ST_RD_REQ:  if (i_mem_gnt) w_state_next = ST_RD_RESP;
      ST_RD_RESP: w_state_next = w_amo ? ST_AMO : ST_WR_REQ;
      ST_AMO:     w_state_next = ST_WR_REQ;
      ST_WR_REQ:  if (i_mem_gnt) w_state_next = ST_FINISH;
      ST_FINISH:  if (!w_amo || i_resp_ready) w_state_next = ST_IDLE;
      default:    w_state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= ST_IDLE;
    end else begin
      r_state <= w_state_next;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_addr <= i_addr;
      r_op   <= i_op;
      r_data <= w_in_data;
      r_strb <= w_in_strb;
    end else begin
      case (r_state)
        ST_RD_RESP: begin
          r_data    <= w_fill;
          r_strb    <= w_strb;
          r_amo_old <= i_mem_rdata[w_sel*WORD_W +: WORD_W];
        end
        ST_AMO: r_data[w_sel*WORD_W +: WORD_W] <= i_amo_result;
        default: begin
          if (i_merge) begin
            r_data <= w_data;
            r_strb <= w_strb;
          end
        end
      endcase
    end
  end

  assign o_valid     = (r_state != ST_IDLE);
  assign o_line_addr = r_addr[P_ADDR_W-1:WSEL_W];
  assign o_mergeable = (r_state == ST_RD_REQ) || (r_state == ST_RD_RESP);
  assign o_is_amo    = w_amo;

  assign o_mem_req_valid     = (r_state == ST_RD_REQ) || (r_state == ST_WR_REQ);
  assign o_mem_req.wr        = (r_state == ST_WR_REQ);
  assign o_mem_req.line_addr = LINE_ADDR_W'(o_line_addr);
  assign o_mem_req.data      = r_data;

  // Zero outside ST_AMO so the top can OR all entries together
  assign o_amo_old     = (r_state == ST_AMO) ? r_amo_old : '0;
  assign o_amo_operand = (r_state == ST_AMO) ? r_data[w_sel*WORD_W +: WORD_W] : '0;
  assign o_amo_op      = (r_state == ST_AMO) ? r_op : OP_STORE;

  assign o_resp.addr  = ADDR_W'(r_addr);
  assign o_resp.data  = r_amo_old;
  assign o_resp_valid = (r_state == ST_FINISH) && w_amo;

endmodule

// File: src/stbuf_data_ram.sv
// ----------------------------------------------------------------------
// Line memory
// One port, read or write per cycle. A write lands on the granting edge,
// read data appears one cycle after the granted read. Cleared at reset.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module stbuf_data_ram
  import stbuf_cfg_pkg::*;
  import stbuf_op_pkg::*;
#(
  parameter int P_ADDR_W = ADDR_W
) (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_valid,
  input  mem_req_t          i_req,
  output logic [LINE_W-1:0] o_rdata
);

  localparam int LA_W  = P_ADDR_W - WSEL_W;
  localparam int LINES = 2 ** LA_W;

  logic [LINE_W-1:0] r_mem [LINES];
  logic [LA_W-1:0]   w_idx;

  assign w_idx = i_req.line_addr[LA_W-1:0];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < LINES; i++) begin
        r_mem[i] <= '0;
      end
      o_rdata <= '0;
    end else if (i_valid) begin
      if (i_req.wr) begin
        r_mem[w_idx] <= i_req.data;
      end else begin
        o_rdata <= r_mem[w_idx];  // Registered read
      end
    end
  end

endmodule

// File: src/stbuf_arbiter.sv
// ----------------------------------------------------------------------
// Round-robin arbiter
// Picks one requester per cycle and forwards its payload. Priority moves
// past the winner after a transfer; a stalled winner keeps the grant so
// its payload stays stable.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module stbuf_arbiter #(
  parameter int  P_NUM     = 2,
  parameter type T_PAYLOAD = logic
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic [P_NUM-1:0] i_req,
  input  T_PAYLOAD         i_payload [P_NUM],
  input  logic             i_ready,
  output logic [P_NUM-1:0] o_gnt,     // One-hot
  output logic             o_valid,
  output T_PAYLOAD         o_payload
);

  localparam int IDX_W = (P_NUM > 1) ? $clog2(P_NUM) : 1;

  logic [IDX_W-1:0] r_last;  // Last winner
  logic             r_lock;  // Winner stalled last cycle
  logic [IDX_W-1:0] w_win;

  always_comb begin
    int idx;
    w_win = r_last;
    // Search downward so the nearest requester after r_last wins
    for (int i = P_NUM; i >= 1; i--) begin
      idx = int'(r_last) + i;
      if (idx >= P_NUM) begin
        idx = idx - P_NUM;
      end
      if (i_req[idx]) begin
        w_win = IDX_W'(idx);
      end
    end
    if (r_lock && i_req[r_last]) begin
      w_win = r_last;
    end
  end

  always_comb begin
    o_gnt        = '0;
    o_gnt[w_win] = |i_req;
  end

  assign o_valid   = |i_req;
  assign o_payload = i_payload[w_win];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_last <= '0;
      r_lock <= 1'b0;
    end else begin
      r_lock <= o_valid && !i_ready;
      if (o_valid) begin
        r_last <= w_win;
      end
    end
  end

endmodule

// File: src/stbuf_amo_alu.sv
// ----------------------------------------------------------------------
// AMO result unit
// Combines the old memory word with the request operand. One copy is
// shared by all entries, since only one entry sits in ST_AMO at a time.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module stbuf_amo_alu
  import stbuf_cfg_pkg::*;
  import stbuf_op_pkg::*;
(
  input  stbuf_op_t         i_op,
  input  logic [WORD_W-1:0] i_old,
  input  logic [WORD_W-1:0] i_operand,
  output logic [WORD_W-1:0] o_result
);

  logic w_old_gt;  // Signed compare for MAX and MIN

  assign w_old_gt = ($signed(i_old) > $signed(i_operand));

  always_comb begin
    case (i_op)
      OP_SWAP: o_result = i_operand;
      OP_ADD:  o_result = i_old + i_operand;
      OP_AND:  o_result = i_old & i_operand;
      OP_OR:   o_result = i_old | i_operand;
      OP_XOR:  o_result = i_old ^ i_operand;
      OP_MAX:  o_result = w_old_gt ? i_old : i_operand;
      OP_MIN:  o_result = w_old_gt ? i_operand : i_old;
      default: o_result = i_old;  // Store leaves the word alone
    endcase
  end

endmodule

// File: src/stbuf_op_pkg.sv
// ----------------------------------------------------------------------
// Operation codes, entry FSM states and arbiter payloads
// Shared by the entries, the AMO unit, the line memory and the top.
// Payload fields are sized for the widest address; narrower
// configurations zero-extend into them.
// ----------------------------------------------------------------------

package stbuf_op_pkg;

  import stbuf_cfg_pkg::*;

  typedef enum logic [2:0] {
    OP_STORE = 3'd0,  // Plain store, no response
    OP_SWAP  = 3'd1,
    OP_ADD   = 3'd2,
    OP_AND   = 3'd3,
    OP_OR    = 3'd4,
    OP_XOR   = 3'd5,
    OP_MAX   = 3'd6,  // Signed
    OP_MIN   = 3'd7   // Signed
  } stbuf_op_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_REQ,
    ST_RD_RESP,
    ST_AMO,
    ST_WR_REQ,
    ST_FINISH
  } stbuf_state_t;

  // Memory arbiter payload
  typedef struct packed {
    logic                   wr;
    logic [LINE_ADDR_W-1:0] line_addr;
    logic [LINE_W-1:0]      data;
  } mem_req_t;

  // Response arbiter payload
  typedef struct packed {
    logic [ADDR_W-1:0] addr;  // Word address
    logic [WORD_W-1:0] data;  // Old word
  } amo_resp_t;

endpackage

// File: src/stbuf_cfg_pkg.sv
// ----------------------------------------------------------------------
// Sizing constants for the store buffer
// Word addresses, line and word widths, and the default entry count.
// Import wherever a width or a byte count is needed.
// ----------------------------------------------------------------------

package stbuf_cfg_pkg;

  localparam int ADDR_W         = 6;   // Default word address width
  localparam int WORD_W         = 32;
  localparam int LINE_W         = 64;  // Two words per line

  localparam int WORD_BYTES     = WORD_W / 8;
  localparam int LINE_BYTES     = LINE_W / 8;
  localparam int WORDS_PER_LINE = LINE_W / WORD_W;

  // Word select bits sit below the line address
  localparam int WSEL_W         = $clog2(WORDS_PER_LINE);
  localparam int LINE_ADDR_W    = ADDR_W - WSEL_W;

  localparam int NUM_ENTRIES    = 4;

endpackage
